//--- common/delay_pkg.sv
`default_nettype none

package delay_pkg;

	localparam int data_width    = 16;
	localparam int addr_width    = 12;
	localparam int sram_capacity = 4096;
	localparam int n_buffers     = 32;
	localparam int handle_width  = 5;

	// gain is signed q1.15, so unity sits one bit above the sample range
	localparam int gain_width = 17;
	localparam logic signed [gain_width-1:0] gain_unity = 17'sd32768;
	localparam int gain_shift = 15;
	localparam logic signed [gain_width-1:0] gain_step = 17'sd256;

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} op_t;

	// the same request word carries a sample on writes and a delay on reads
	typedef union packed {
		logic signed [data_width-1:0] sample;
		// offset in the low addr_width bits, upper bits unused
		logic [data_width-1:0] delay;
	} req_arg_t;

	// allocation handshake states
	localparam logic [1:0] alloc_idle   = 2'd0;
	localparam logic [1:0] alloc_check  = 2'd1;
	localparam logic [1:0] alloc_commit = 2'd2;
	localparam logic [1:0] alloc_done   = 2'd3;

	// access sequencer states
	localparam logic [2:0] seq_idle     = 3'd0;
	localparam logic [2:0] seq_lookup   = 3'd1;
	localparam logic [2:0] seq_dispatch = 3'd2;
	localparam logic [2:0] seq_write    = 3'd3;
	localparam logic [2:0] seq_mem      = 3'd4;
	localparam logic [2:0] seq_mult     = 3'd5;
	localparam logic [2:0] seq_out      = 3'd6;
	localparam logic [2:0] seq_ack      = 3'd7;

endpackage

`default_nettype wire

//--- design/descriptor_table.sv
`timescale 1ns/100ps
`default_nettype none

module descriptor_table (
	input  wire clk,
	input  wire reset,
	input  wire alloc_req,
	input  wire [delay_pkg::addr_width-1:0] alloc_size,
	output logic alloc_ack,
	output logic alloc_invalid,
	output logic [delay_pkg::handle_width-1:0] alloc_handle,
	input  wire [delay_pkg::data_width-1:0] lookup_handle,
	output logic desc_valid,
	output logic [delay_pkg::addr_width-1:0] desc_base,
	output logic [delay_pkg::addr_width-1:0] desc_size,
	output logic [delay_pkg::addr_width-1:0] desc_position,
	output logic desc_wrapped,
	output logic signed [delay_pkg::gain_width-1:0] desc_gain,
	input  wire advance,
	input  wire [delay_pkg::handle_width-1:0] advance_handle,
	output logic [delay_pkg::handle_width:0] buffer_count
);
	import delay_pkg::*;

	logic [addr_width-1:0] base_r [n_buffers];
	logic [addr_width-1:0] size_r [n_buffers];
	logic [addr_width-1:0] pos_r [n_buffers];
	logic signed [gain_width-1:0] gain_r [n_buffers];
	logic [n_buffers-1:0] wrapped_r;

	// one bit wider so a completely filled memory does not wrap to zero
	logic [addr_width:0] next_free;
	logic [1:0] alloc_state;
	logic [addr_width-1:0] alloc_size_q;
	logic alloc_ok_q;

	wire size_pow2 = (alloc_size_q != '0) &&
		((alloc_size_q & (alloc_size_q - 1'b1)) == '0);
	wire [addr_width:0] alloc_end = next_free + {1'b0, alloc_size_q};
	wire alloc_fits = alloc_end <= (addr_width + 1)'(sram_capacity);
	wire table_free = buffer_count < (handle_width + 1)'(n_buffers);

	wire [handle_width-1:0] lookup_idx = lookup_handle[handle_width-1:0];
	wire lookup_in_range = (lookup_handle[data_width-1:handle_width] == '0) &&
		({1'b0, lookup_idx} < buffer_count);

	wire [addr_width-1:0] adv_pos = pos_r[advance_handle];
	wire [addr_width-1:0] adv_mask = size_r[advance_handle] - 1'b1;
	wire signed [gain_width-1:0] adv_gain = gain_r[advance_handle];

	always_ff @(posedge clk) begin
		if (reset) begin
			alloc_state <= alloc_idle;
			alloc_ack <= 1'b0;
			alloc_invalid <= 1'b0;
			next_free <= '0;
			buffer_count <= '0;
			wrapped_r <= '0;
			desc_valid <= 1'b0;
			for (int i = 0; i < n_buffers; i++) begin
				pos_r[i] <= '0;
				gain_r[i] <= '0;
			end
		end else begin
			desc_valid <= lookup_in_range;

			case (alloc_state)
				alloc_idle: begin
					if (alloc_req) begin
						alloc_size_q <= alloc_size;
						alloc_state <= alloc_check;
					end
				end
				alloc_check: begin
					alloc_ok_q <= size_pow2 && alloc_fits && table_free;
					alloc_state <= alloc_commit;
				end
				alloc_commit: begin
					if (alloc_ok_q) begin
						base_r[buffer_count[handle_width-1:0]] <= next_free[addr_width-1:0];
						size_r[buffer_count[handle_width-1:0]] <= alloc_size_q;
						pos_r[buffer_count[handle_width-1:0]] <= '0;
						gain_r[buffer_count[handle_width-1:0]] <= '0;
						wrapped_r[buffer_count[handle_width-1:0]] <= 1'b0;
						alloc_handle <= buffer_count[handle_width-1:0];
						next_free <= alloc_end;
						buffer_count <= buffer_count + 1'b1;
					end
					alloc_invalid <= ~alloc_ok_q;
					alloc_ack <= 1'b1;
					alloc_state <= alloc_done;
				end
				default: begin
					// hold the result until the host lets go
					if (!alloc_req) begin
						alloc_ack <= 1'b0;
						alloc_invalid <= 1'b0;
						alloc_state <= alloc_idle;
					end
				end
			endcase

			if (advance) begin
				if (adv_pos == adv_mask)
					wrapped_r[advance_handle] <= 1'b1;
				// ramp only counts writes after the first full lap
				if (wrapped_r[advance_handle] && adv_gain < gain_unity)
					gain_r[advance_handle] <= adv_gain + gain_step;
				pos_r[advance_handle] <= (adv_pos + 1'b1) & adv_mask;
			end
		end
	end

	always_ff @(posedge clk) begin
		desc_base <= base_r[lookup_idx];
		desc_size <= size_r[lookup_idx];
		desc_position <= pos_r[lookup_idx];
		desc_wrapped <= wrapped_r[lookup_idx];
		desc_gain <= gain_r[lookup_idx];
	end

	gain_bounded: assert property (@(posedge clk) disable iff (reset)
		advance |=> gain_r[$past(advance_handle)] <= gain_unity + gain_step);

endmodule

`default_nettype wire

//--- design/sample_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sample_ram (
	input  wire clk,
	input  wire wr_en,
	input  wire [delay_pkg::addr_width-1:0] wr_addr,
	input  wire [delay_pkg::data_width-1:0] wr_data,
	input  wire [delay_pkg::addr_width-1:0] rd_addr,
	output logic [delay_pkg::data_width-1:0] rd_data
);
	import delay_pkg::*;

	logic [data_width-1:0] mem [sram_capacity];

	// read returns the old word if both ports hit the same address
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- access_sequencer/access_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module access_sequencer (
	input  wire clk,
	input  wire reset,
	input  wire acc_req,
	input  wire delay_pkg::op_t acc_op,
	input  wire [delay_pkg::data_width-1:0] acc_handle,
	input  wire delay_pkg::req_arg_t acc_arg,
	output logic acc_ack,
	output logic acc_invalid,
	output logic [delay_pkg::data_width-1:0] acc_data,
	output logic [delay_pkg::data_width-1:0] lookup_handle,
	input  wire desc_valid,
	input  wire [delay_pkg::addr_width-1:0] desc_base,
	input  wire [delay_pkg::addr_width-1:0] desc_size,
	input  wire [delay_pkg::addr_width-1:0] desc_position,
	input  wire desc_wrapped,
	input  wire signed [delay_pkg::gain_width-1:0] desc_gain,
	output logic advance,
	output logic [delay_pkg::handle_width-1:0] advance_handle,
	output logic wr_en,
	output logic [delay_pkg::addr_width-1:0] wr_addr,
	output logic [delay_pkg::data_width-1:0] wr_data,
	output logic [delay_pkg::addr_width-1:0] rd_addr,
	input  wire [delay_pkg::data_width-1:0] rd_data
);
	import delay_pkg::*;

	logic [2:0] state;
	logic [data_width-1:0] handle_q;
	op_t op_q;
	req_arg_t arg_q;
	logic signed [gain_width-1:0] gain_q;
	logic signed [data_width+gain_width-1:0] product_q;

	// sizes are powers of two, so size minus one is the wrap mask
	wire [addr_width-1:0] size_mask = desc_size - 1'b1;
	wire [addr_width-1:0] read_offset =
		(desc_position - arg_q.delay[addr_width-1:0]) & size_mask;
	wire signed [data_width+gain_width-1:0] scaled = product_q >>> gain_shift;

	assign lookup_handle = handle_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_idle;
			acc_ack <= 1'b0;
			acc_invalid <= 1'b0;
			wr_en <= 1'b0;
			advance <= 1'b0;
		end else begin
			case (state)
				seq_idle: begin
					if (acc_req)
						state <= seq_lookup;
				end
				seq_lookup: state <= seq_dispatch;
				seq_dispatch: begin
					if (!desc_valid) begin
						acc_invalid <= 1'b1;
						acc_ack <= 1'b1;
						state <= seq_ack;
					end else if (op_q == op_write) begin
						wr_en <= 1'b1;
						advance <= 1'b1;
						state <= seq_write;
					end else begin
						state <= seq_mem;
					end
				end
				seq_write: begin
					wr_en <= 1'b0;
					advance <= 1'b0;
					acc_ack <= 1'b1;
					state <= seq_ack;
				end
				seq_mem: state <= seq_mult;
				seq_mult: state <= seq_out;
				seq_out: begin
					acc_ack <= 1'b1;
					state <= seq_ack;
				end
				default: begin
					if (!acc_req) begin
						acc_ack <= 1'b0;
						acc_invalid <= 1'b0;
						state <= seq_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			seq_idle: begin
				if (acc_req) begin
					handle_q <= acc_handle;
					op_q <= acc_op;
					arg_q <= acc_arg;
				end
			end
			seq_dispatch: begin
				wr_addr <= desc_base + desc_position;
				wr_data <= arg_q.sample;
				advance_handle <= handle_q[handle_width-1:0];
				rd_addr <= desc_base + read_offset;
				// an unwrapped buffer reads as silence
				gain_q <= desc_wrapped ? desc_gain : '0;
				if (!desc_valid || op_q == op_write)
					acc_data <= '0;
			end
			seq_mult: product_q <= $signed(rd_data) * gain_q;
			seq_out: acc_data <= scaled[data_width-1:0];
			default: begin
			end
		endcase
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(acc_ack) |-> acc_req);

	write_with_advance: assert property (@(posedge clk) disable iff (reset)
		wr_en == advance);

endmodule

`default_nettype wire

//--- design/delay_line_bank.sv
`timescale 1ns/100ps
`default_nettype none

module delay_line_bank (
	input  wire clk,
	input  wire reset,
	input  wire alloc_req,
	input  wire [delay_pkg::addr_width-1:0] alloc_size,
	output wire alloc_ack,
	output wire alloc_invalid,
	output wire [delay_pkg::handle_width-1:0] alloc_handle,
	input  wire acc_req,
	input  wire delay_pkg::op_t acc_op,
	input  wire [delay_pkg::data_width-1:0] acc_handle,
	input  wire delay_pkg::req_arg_t acc_arg,
	output wire acc_ack,
	output wire acc_invalid,
	output wire [delay_pkg::data_width-1:0] acc_data
);
	import delay_pkg::*;

	wire [data_width-1:0] lookup_handle;
	wire desc_valid;
	wire [addr_width-1:0] desc_base;
	wire [addr_width-1:0] desc_size;
	wire [addr_width-1:0] desc_position;
	wire desc_wrapped;
	wire signed [gain_width-1:0] desc_gain;
	wire advance;
	wire [handle_width-1:0] advance_handle;
	wire [handle_width:0] buffer_count;
	wire wr_en;
	wire [addr_width-1:0] wr_addr;
	wire [data_width-1:0] wr_data;
	wire [addr_width-1:0] rd_addr;
	wire [data_width-1:0] rd_data;

	descriptor_table u_table (
		.clk(clk),
		.reset(reset),
		.alloc_req(alloc_req),
		.alloc_size(alloc_size),
		.alloc_ack(alloc_ack),
		.alloc_invalid(alloc_invalid),
		.alloc_handle(alloc_handle),
		.lookup_handle(lookup_handle),
		.desc_valid(desc_valid),
		.desc_base(desc_base),
		.desc_size(desc_size),
		.desc_position(desc_position),
		.desc_wrapped(desc_wrapped),
		.desc_gain(desc_gain),
		.advance(advance),
		.advance_handle(advance_handle),
		.buffer_count(buffer_count)
	);

	sample_ram u_ram (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	access_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.acc_req(acc_req),
		.acc_op(acc_op),
		.acc_handle(acc_handle),
		.acc_arg(acc_arg),
		.acc_ack(acc_ack),
		.acc_invalid(acc_invalid),
		.acc_data(acc_data),
		.lookup_handle(lookup_handle),
		.desc_valid(desc_valid),
		.desc_base(desc_base),
		.desc_size(desc_size),
		.desc_position(desc_position),
		.desc_wrapped(desc_wrapped),
		.desc_gain(desc_gain),
		.advance(advance),
		.advance_handle(advance_handle),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

//--- tb/tb_delay_line_bank.sv
`timescale 1ns/100ps
`default_nettype none

module tb_delay_line_bank;
	import delay_pkg::*;

	localparam int timeout_cycles = 50;

	logic clk;
	logic reset;
	logic alloc_req;
	logic [addr_width-1:0] alloc_size;
	wire alloc_ack;
	wire alloc_invalid;
	wire [handle_width-1:0] alloc_handle;
	logic acc_req;
	op_t acc_op;
	logic [data_width-1:0] acc_handle;
	req_arg_t acc_arg;
	wire acc_ack;
	wire acc_invalid;
	wire [data_width-1:0] acc_data;

	// reference model of the descriptor table and sample memory
	int ref_base [n_buffers];
	int ref_size [n_buffers];
	int ref_pos [n_buffers];
	int ref_gain [n_buffers];
	bit ref_wrapped [n_buffers];
	logic signed [data_width-1:0] ref_mem [sram_capacity];
	int ref_count;
	int ref_free;

	logic [31:0] lcg_state;
	string test_name;
	logic [data_width-1:0] exp_data;
	logic exp_invalid;
	bit ack_prev;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	int test_count;

	delay_line_bank u_dut (
		.clk(clk),
		.reset(reset),
		.alloc_req(alloc_req),
		.alloc_size(alloc_size),
		.alloc_ack(alloc_ack),
		.alloc_invalid(alloc_invalid),
		.alloc_handle(alloc_handle),
		.acc_req(acc_req),
		.acc_op(acc_op),
		.acc_handle(acc_handle),
		.acc_arg(acc_arg),
		.acc_ack(acc_ack),
		.acc_invalid(acc_invalid),
		.acc_data(acc_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// returns {invalid, handle}
	function automatic logic [5:0] ref_alloc(input int size);
		if (size == 0 || (size & (size - 1)) != 0 || ref_free + size > sram_capacity ||
				ref_count >= n_buffers)
			return {1'b1, 5'd0};
		ref_base[ref_count] = ref_free;
		ref_size[ref_count] = size;
		ref_pos[ref_count] = 0;
		ref_gain[ref_count] = 0;
		ref_wrapped[ref_count] = 1'b0;
		ref_free += size;
		ref_count++;
		return {1'b0, 5'(ref_count - 1)};
	endfunction

	// returns {invalid, data}
	function automatic logic [16:0] ref_access(input bit is_write, input logic [15:0] h,
			input logic [15:0] arg);
		int idx;
		int off;
		int prod;
		if (int'(h) >= ref_count)
			return {1'b1, 16'h0};
		idx = int'(h);
		if (is_write) begin
			ref_mem[ref_base[idx] + ref_pos[idx]] = arg;
			// gain only moves on writes after the first full lap
			if (ref_wrapped[idx] && ref_gain[idx] < 32768)
				ref_gain[idx] += 256;
			if (ref_pos[idx] == ref_size[idx] - 1)
				ref_wrapped[idx] = 1'b1;
			ref_pos[idx] = (ref_pos[idx] + 1) % ref_size[idx];
			return {1'b0, 16'h0};
		end
		off = ((ref_pos[idx] - int'(arg[11:0])) % ref_size[idx] + ref_size[idx]) % ref_size[idx];
		prod = int'(ref_mem[ref_base[idx] + off]) * ref_gain[idx];
		prod = prod >>> 15;
		return {1'b0, prod[15:0]};
	endfunction

	// largest delay that only reaches words already written
	function automatic int read_limit(input int h);
		return ref_wrapped[h] ? ref_size[h] : ref_pos[h];
	endfunction

	task automatic give_up(input string what);
		$display("timeout in test %s: %s", test_name, what);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic check_alloc(input int size);
		logic [5:0] want;
		logic [4:0] got_handle;
		logic got_invalid;
		int cnt;
		want = ref_alloc(size);
		@(posedge clk);
		alloc_req <= 1'b1;
		alloc_size <= 12'(size);
		cnt = 0;
		while (!alloc_ack && cnt < timeout_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (!alloc_ack)
			give_up("allocation ack never rose");
		got_handle = alloc_handle;
		got_invalid = alloc_invalid;
		@(posedge clk);
		alloc_req <= 1'b0;
		cnt = 0;
		while (alloc_ack && cnt < timeout_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (alloc_ack)
			give_up("allocation ack stayed high after req fell");
		test_checks++;
		assert (got_invalid === want[5] && (want[5] || got_handle === want[4:0])) else begin
			test_errors++;
			$display("error %s: expected invalid %b handle %0d, actual invalid %b handle %0d",
				test_name, want[5], want[4:0], got_invalid, got_handle);
		end
	endtask

	task automatic do_access(input bit is_write, input logic [15:0] h, input logic [15:0] arg);
		int cnt;
		{exp_invalid, exp_data} = ref_access(is_write, h, arg);
		@(posedge clk);
		acc_req <= 1'b1;
		acc_op <= is_write ? op_write : op_read;
		acc_handle <= h;
		acc_arg <= arg;
		cnt = 0;
		while (!acc_ack && cnt < timeout_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (!acc_ack)
			give_up("access ack never rose");
		@(posedge clk);
		acc_req <= 1'b0;
		cnt = 0;
		while (acc_ack && cnt < timeout_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (acc_ack)
			give_up("access ack stayed high after req fell");
	endtask

	// each rising ack is compared while the result is held
	always @(negedge clk) begin
		if (acc_ack && !ack_prev) begin
			test_checks++;
			assert (acc_invalid === exp_invalid && acc_data === exp_data) else begin
				test_errors++;
				$display("error %s: expected data %h invalid %b, actual data %h invalid %b",
					test_name, exp_data, exp_invalid, acc_data, acc_invalid);
			end
		end
		ack_prev = acc_ack;
	end

	task automatic finish_test();
		$display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_count++;
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		logic [31:0] r;
		int h;
		int lim;
		reset = 1'b1;
		alloc_req = 1'b0;
		alloc_size = '0;
		acc_req = 1'b0;
		acc_op = op_read;
		acc_handle = '0;
		acc_arg = '0;
		lcg_state = 32'h5afd_8369;
		ref_count = 0;
		ref_free = 0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		test_name = "alloc";
		check_alloc(8);
		check_alloc(16);
		check_alloc(4);
		// a handle one past the last buffer while its upper bits are still zero
		do_access(1'b0, 16'(ref_count), 16'd1);
		check_alloc(12);
		check_alloc(2048);
		// second half of the memory no longer fits
		check_alloc(2048);
		for (int i = 0; i < 28; i++)
			check_alloc(4);
		check_alloc(4);
		finish_test();

		test_name = "unwrapped";
		for (int i = 0; i < 5; i++) begin
			r = next_random();
			do_access(1'b1, 16'd0, r[15:0]);
		end
		for (int d = 1; d <= 5; d++)
			do_access(1'b0, 16'd0, 16'(d));
		finish_test();

		test_name = "gain_ramp";
		for (int i = 0; i < 160; i++) begin
			r = next_random();
			do_access(1'b1, 16'd2, r[15:0]);
			for (int d = 1; d <= read_limit(2); d++)
				do_access(1'b0, 16'd2, 16'(d));
		end
		finish_test();

		test_name = "invalid";
		do_access(1'b0, 16'(ref_count), 16'd1);
		do_access(1'b1, 16'h8002, 16'h1234);
		do_access(1'b0, 16'h0402, 16'd1);
		do_access(1'b0, 16'd2, 16'd1);
		do_access(1'b0, 16'd2, 16'd4);
		finish_test();

		test_name = "random";
		for (int i = 0; i < 300; i++) begin
			r = next_random();
			h = int'(r[28:24]);
			lim = read_limit(h);
			if (r[31] || lim == 0)
				do_access(1'b1, 16'(h), r[15:0]);
			else
				do_access(1'b0, 16'(h), 16'(1 + int'(next_random() >> 8) % lim));
		end
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", test_count, total_checks, total_errors);
		if (total_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
common/delay_pkg.sv
design/descriptor_table.sv
design/sample_ram.sv
access_sequencer/access_sequencer.sv
design/delay_line_bank.sv
tb/tb_delay_line_bank.sv

//--- run_sim.sh
#!/bin/bash
# build the delay line bank testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_delay_line_bank -o tb_delay_line_bank

./obj_dir/tb_delay_line_bank | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"
